/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter real PERIOD = 40.0                              // ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2.0) clk = ~clk;                        // free running, 50 percent duty

endmodule

/* dv/tb_cnn_model.svh */
`ifndef TB_CNN_MODEL_SVH
`define TB_CNN_MODEL_SVH

localparam int NUM_RUNS = 6;                                  // tables run back to back

layer_desc_t run_desc [NUM_RUNS][`CNN_MAX_LAYERS];           // one table per run
int unsigned run_num  [NUM_RUNS];                            // layers used per run
out_pos_t    exp_pos  [$];                                   // positions still to come
layer_desc_t exp_desc [$];                                   // launches still to come

function automatic int unsigned size_of(input layer_desc_t d);
	return (d.fm_size_out == 0) ? 1 : int'(d.fm_size_out);   // zero size acts as one
endfunction

function automatic int unsigned groups_of(input layer_desc_t d);
	int unsigned g;
	g = (int'(d.kernel_num) + `CNN_PARA_KERNEL - 1) / `CNN_PARA_KERNEL; // ceiling
	return (g == 0) ? 1 : g;
endfunction

function automatic int unsigned layer_beats(input layer_desc_t d);
	return size_of(d) * size_of(d) * groups_of(d);
endfunction

// issue and next add two clocks per layer
function automatic cycle_cnt_t run_cycles(input int run);
	int unsigned total;
	total = 0;
	for (int l = 0; l < run_num[run]; l++) begin
		total += layer_beats(run_desc[run][l]) + 2;
	end
	return cycle_cnt_t'(total);
endfunction

// kgroup outermost, then row, col innermost
task automatic expect_run(input int run);
	layer_desc_t d;
	out_pos_t    p;
	for (int l = 0; l < run_num[run]; l++) begin
		d = run_desc[run][l];
		exp_desc.push_back(d);
		for (int g = 0; g < groups_of(d); g++) begin
			for (int r = 0; r < size_of(d); r++) begin
				for (int c = 0; c < size_of(d); c++) begin
					p.kgroup = kgroup_t'(g);
					p.row    = fm_size_t'(r);
					p.col    = fm_size_t'(c);
					exp_pos.push_back(p);
				end
			end
		end
	end
endtask

function automatic axi_data_t desc_word0(input layer_desc_t d);
	axi_data_t w;
	w       = '0;
	w[1:0]  = d.kind;
	w[2]    = d.activation;
	w[3]    = d.pool_type;
	w[13:8] = d.kernel_size;
	return w;
endfunction

function automatic axi_data_t desc_word1(input layer_desc_t d);
	axi_data_t w;
	w       = '0;
	w[5:0]  = d.fm_size_out;
	w[13:8] = d.kernel_num;
	return w;
endfunction

`endif

/* dv/tb_cnn_ctrl.sv */
`timescale 1ns/1ps
`include "cnn_defines.svh"

module tb_cnn_ctrl import cnn_pkg::*; ();

	logic        clk;
	logic        rst;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	layer_desc_t cur_desc;
	logic        layer_go;
	logic        pos_valid;
	out_pos_t    pos;
	logic        stop;

	logic [31:0] rng_state   = 32'd62800;                   // xorshift state
	int unsigned value_errs  = 0;                            // wrong values
	int unsigned flow_errs   = 0;                            // missing or extra beats, flags
	int unsigned cycle_cnt   = 0;
	int unsigned cycle_limit = 2000;                         // raised once tables exist

	`include "tb_cnn_model.svh"

	tb_clk_gen clk_i (.clk(clk));

	cnn_ctrl_top dut_i (
		.clk       (clk),
		.rst       (rst),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.cur_desc  (cur_desc),
		.layer_go  (layer_go),
		.pos_valid (pos_valid),
		.pos       (pos),
		.stop      (stop)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
		return lo + (next_word() % (hi - lo + 1));
	endfunction

	task automatic check_pos(input out_pos_t got, input out_pos_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED at %0t: position k%0d r%0d c%0d, expected k%0d r%0d c%0d",
				$time, got.kgroup, got.row, got.col, exp.kgroup, exp.row, exp.col);
		end
	endtask

	task automatic check_desc(input layer_desc_t got, input layer_desc_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED at %0t: descriptor %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_cycles(input cycle_cnt_t got, input cycle_cnt_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED at %0t: cycles %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_data(input axi_data_t got, input axi_data_t exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// aw and w together, then wait out the response
	task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
		@(posedge clk);
		axil_req.awaddr  <= addr;
		axil_req.wdata   <= data;
		axil_req.awvalid <= 1'b1;
		axil_req.wvalid  <= 1'b1;
		axil_req.bready  <= 1'b1;
		do @(posedge clk); while (!axil_rsp.awready);
		if (axil_rsp.wready !== 1'b1) begin
			flow_errs++;
			$display("at %0t wready did not pulse together with awready", $time);
		end
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		do @(posedge clk); while (!axil_rsp.bvalid);
		check_data(axi_data_t'(axil_rsp.bresp), '0, "write response");
		axil_req.bready  <= 1'b0;                            // bvalid drops on this edge
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
		@(posedge clk);
		axil_req.araddr  <= addr;
		axil_req.arvalid <= 1'b1;
		axil_req.rready  <= 1'b1;
		do @(posedge clk); while (!axil_rsp.arready);
		axil_req.arvalid <= 1'b0;
		do @(posedge clk); while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		check_data(axi_data_t'(axil_rsp.rresp), '0, "read response");
		axil_req.rready  <= 1'b0;
	endtask

	task automatic read_expect(input axi_addr_t addr, input axi_data_t exp, input string what);
		axi_data_t rd;
		axi_read(addr, rd);
		check_data(rd, exp, what);
	endtask

	task automatic make_tables();
		for (int r = 0; r < NUM_RUNS; r++) begin
			run_num[r] = rand_range(1, `CNN_MAX_LAYERS);
			for (int l = 0; l < `CNN_MAX_LAYERS; l++) begin
				run_desc[r][l].kind        = layer_kind_e'(rand_range(0, 2));
				run_desc[r][l].activation  = 1'(next_word());
				run_desc[r][l].pool_type   = 1'(next_word());
				run_desc[r][l].kernel_size = kernel_size_t'(rand_range(1, 40));
				run_desc[r][l].fm_size_out = fm_size_t'(rand_range(1, 8));
				run_desc[r][l].kernel_num  = kernel_num_t'(rand_range(1, 12));
			end
		end
		run_num[0]                = 3;                        // odd and even counts, long enough
		run_desc[0][0].fm_size_out = fm_size_t'(4);
		run_desc[0][0].kernel_num  = kernel_num_t'(5);
		run_desc[0][1].kernel_num  = kernel_num_t'(4);
		run_desc[1][0].fm_size_out = fm_size_t'(0);           // zero size and no kernels, one beat
		run_desc[1][0].kernel_num  = kernel_num_t'(0);
	endtask

	task automatic do_run(input int run);
		axi_data_t rd;
		axi_addr_t base;
		for (int l = 0; l < `CNN_MAX_LAYERS; l++) begin
			base = axi_addr_t'(8'h10 + 8 * l);
			axi_write(base, desc_word0(run_desc[run][l]) | (next_word() & ~32'h3F0F)); // junk
			axi_write(base + 8'd4, desc_word1(run_desc[run][l]) | (next_word() & ~32'h3F3F));
		end
		axi_write(8'h08, axi_data_t'(run_num[run]) | (next_word() & ~32'h7));
		for (int l = 0; l < `CNN_MAX_LAYERS; l++) begin
			base = axi_addr_t'(8'h10 + 8 * l);
			read_expect(base, desc_word0(run_desc[run][l]), "descriptor word 0");
			read_expect(base + 8'd4, desc_word1(run_desc[run][l]), "descriptor word 1");
		end
		read_expect(8'h08, axi_data_t'(run_num[run]), "NUM_LAYERS");
		if ((run > 0) && !stop) begin
			flow_errs++;
			$display("at %0t stop fell before the next start", $time);
		end
		expect_run(run);
		axi_write(8'h00, 32'h1);                             // start
		@(posedge clk);
		if (stop) begin
			flow_errs++;
			$display("at %0t stop is still high after a new start", $time);
		end
		if (run_cycles(run) > 16) begin
			read_expect(8'h04, 32'h1, "STATUS while busy");
			axi_write(8'h00, 32'h1);                         // must be ignored
		end
		while (!stop) @(posedge clk);
		if (exp_pos.size() != 0) begin
			flow_errs++;
			$display("run %0d ended with %0d position beats missing", run, exp_pos.size());
		end
		if (exp_desc.size() != 0) begin
			flow_errs++;
			$display("run %0d ended with %0d layer launches missing", run, exp_desc.size());
		end
		read_expect(8'h04, 32'h2, "STATUS after run");
		axi_read(8'h0C, rd);
		check_cycles(cycle_cnt_t'(rd), run_cycles(run));
		check_data(rd & ~32'hFF_FFFF, '0, "CYCLES upper bits");
	endtask

	// stream and launch monitor
	always @(posedge clk) begin
		if (rst && pos_valid) begin
			if (exp_pos.size() == 0) begin
				flow_errs++;
				$display("at %0t a position beat arrived with none expected", $time);
			end else begin
				check_pos(pos, exp_pos.pop_front());
			end
		end
		if (rst && layer_go) begin
			if (exp_desc.size() == 0) begin
				flow_errs++;
				$display("at %0t an extra layer launch arrived", $time);
			end else begin
				check_desc(cur_desc, exp_desc.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, the run never finished", cycle_cnt);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		int unsigned total;
		axil_req <= '0;
		rst      <= 1'b0;
		make_tables();
		total = 0;
		for (int r = 0; r < NUM_RUNS; r++) begin
			total += run_cycles(r);
		end
		cycle_limit = 2 * total + 2000;
		repeat (8) @(posedge clk);
		rst <= 1'b1;
		read_expect(8'h30, '0, "unmapped 0x30");
		axi_write(8'h04, 32'hFFFF_FFFF);                     // read only, dropped
		axi_write(8'hFC, 32'hFFFF_FFFF);                     // unmapped, dropped
		read_expect(8'h04, '0, "STATUS after reset");
		read_expect(8'hFC, '0, "unmapped 0xFC");
		read_expect(8'h0C, '0, "CYCLES after reset");
		for (int r = 0; r < NUM_RUNS; r++) begin
			do_run(r);
		end
		$display("errors: %0d value mismatches, %0d stream or flag errors",
			value_errs, flow_errs);
		if (value_errs + flow_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* hdl/cnn_ctrl_top.sv */
`timescale 1ns/1ps
`include "cnn_defines.svh"

module cnn_ctrl_top import cnn_pkg::*; (
	input  logic        clk,
	input  logic        rst,                                  // async, active low
	input  axil_req_t   axil_req,                             // host register port
	output axil_rsp_t   axil_rsp,
	output layer_desc_t cur_desc,                             // to datapath, per layer
	output logic        layer_go,
	output logic        pos_valid,                            // position stream to PE array
	output out_pos_t    pos,
	output logic        stop                                  // whole network finished
);

	logic        start_pulse;
	num_layers_t num_layers;
	layer_desc_t desc_table [0:`CNN_MAX_LAYERS-1];            // host written table
	logic        busy;
	logic        done;
	cycle_cnt_t  cycles;
	logic        layer_done;                                  // walker back to sequencer

	layer_cfg_regs regs_i (
		.clk         (clk),
		.rst         (rst),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp),
		.busy        (busy),
		.done        (done),
		.cycles      (cycles),
		.start_pulse (start_pulse),
		.num_layers  (num_layers),
		.desc_table  (desc_table)
	);

	layer_sequencer seq_i (
		.clk         (clk),
		.rst         (rst),
		.start_pulse (start_pulse),
		.num_layers  (num_layers),
		.desc_table  (desc_table),
		.layer_done  (layer_done),
		.layer_go    (layer_go),
		.cur_desc    (cur_desc),
		.busy        (busy),
		.done        (done),
		.stop        (stop),
		.cycles      (cycles)
	);

	output_walker walker_i (
		.clk        (clk),
		.rst        (rst),
		.layer_go   (layer_go),
		.cur_desc   (cur_desc),
		.pos_valid  (pos_valid),
		.pos        (pos),
		.layer_done (layer_done)
	);

endmodule

/* hdl/cnn_defines.svh */
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// table size and parallelism
`define CNN_MAX_LAYERS    4     // descriptor table entries
`define CNN_PARA_KERNEL   2     // kernels handled per output position

// field widths
`define CNN_FM_SIZE_W     6     // feature map edge
`define CNN_KERNEL_NUM_W  6     // kernel or channel count
`define CNN_KERNEL_SIZE_W 6     // kernel edge, or fc input size
`define CNN_LAYER_IDX_W   2     // table index

// run timer and host bus
`define CNN_CYCLE_W       24    // run cycle counter
`define CNN_AXI_ADDR_W    8     // byte address into register map

`endif

/* hdl/cnn_pkg.sv */
`include "cnn_defines.svh"

package cnn_pkg;

	typedef logic [`CNN_FM_SIZE_W-1:0]     fm_size_t;     // output map edge length
	typedef logic [`CNN_KERNEL_NUM_W-1:0]  kernel_num_t;  // kernels per layer
	typedef logic [`CNN_KERNEL_SIZE_W-1:0] kernel_size_t; // kernel edge or fc input total
	typedef logic [`CNN_KERNEL_NUM_W-1:0]  kgroup_t;      // index of a PARA_KERNEL group
	typedef logic [`CNN_LAYER_IDX_W-1:0]   layer_idx_t;   // table entry
	typedef logic [`CNN_LAYER_IDX_W:0]     num_layers_t;  // 1 .. MAX_LAYERS, needs one more bit
	typedef logic [`CNN_CYCLE_W-1:0]       cycle_cnt_t;   // run length in clocks
	typedef logic [`CNN_AXI_ADDR_W-1:0]    axi_addr_t;
	typedef logic [31:0]                   axi_data_t;

	typedef enum logic [1:0] {CONV = 2'd0, POOL = 2'd1, FC = 2'd2} layer_kind_e;

	typedef enum logic [2:0] {IDLE, ISSUE, RUN, NEXT, DONE} seq_state_e; // layer FSM

	typedef struct packed {
		layer_kind_e  kind;
		logic         activation;  // 0 none, 1 relu
		logic         pool_type;   // 0 max, 1 avg
		kernel_size_t kernel_size;
		fm_size_t     fm_size_out;
		kernel_num_t  kernel_num;  // output depth
	} layer_desc_t;

	typedef struct packed {
		fm_size_t row;
		fm_size_t col;
		kgroup_t  kgroup;
	} out_pos_t;

	typedef struct packed {
		axi_addr_t awaddr;
		logic      awvalid;
		axi_data_t wdata;
		logic      wvalid;
		logic      bready;
		axi_addr_t araddr;
		logic      arvalid;
		logic      rready;
	} axil_req_t; // host to regs

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		logic [1:0] bresp;
		logic       arready;
		logic       rvalid;
		axi_data_t  rdata;
		logic [1:0] rresp;
	} axil_rsp_t; // regs to host

endpackage

/* hdl/layer_cfg_regs.sv */
`timescale 1ns/1ps
`include "cnn_defines.svh"

module layer_cfg_regs import cnn_pkg::*; (
	input  logic        clk,
	input  logic        rst,                                  // async, active low
	input  axil_req_t   axil_req,
	output axil_rsp_t   axil_rsp,
	input  logic        busy,                                 // from sequencer
	input  logic        done,
	input  cycle_cnt_t  cycles,
	output logic        start_pulse,                          // one clock wide
	output num_layers_t num_layers,
	output layer_desc_t desc_table [0:`CNN_MAX_LAYERS-1]
);

	localparam int unsigned WW = `CNN_AXI_ADDR_W - 2;        // word index width

	localparam logic [WW-1:0] CTRL_W    = WW'(0);             // 0x00
	localparam logic [WW-1:0] STATUS_W  = WW'(1);             // 0x04
	localparam logic [WW-1:0] NUM_W     = WW'(2);             // 0x08
	localparam logic [WW-1:0] CYCLES_W  = WW'(3);             // 0x0C
	localparam logic [WW-1:0] DESC_W    = WW'(4);             // 0x10, first descriptor word
	localparam logic [WW-1:0] DESC_END  = WW'(4 + 2 * `CNN_MAX_LAYERS);

	logic          w_fire;                                    // aw and w taken together
	logic          r_fire;
	logic          bvalid;
	logic          rvalid;
	axi_data_t     rdata;                                     // held read data
	axi_data_t     rd_word;                                   // read mux
	logic [WW-1:0] w_word;
	logic [WW-1:0] r_word;
	logic [WW-1:0] w_off;                                     // offset into table
	logic [WW-1:0] r_off;
	logic          w_desc;
	logic          r_desc;
	layer_idx_t    w_idx;
	layer_idx_t    r_idx;

	assign w_fire = axil_req.awvalid && axil_req.wvalid && !bvalid; // one write in flight
	assign r_fire = axil_req.arvalid && !rvalid;

	assign w_word = axil_req.awaddr[`CNN_AXI_ADDR_W-1:2];     // byte lanes ignored
	assign r_word = axil_req.araddr[`CNN_AXI_ADDR_W-1:2];
	assign w_off  = w_word - DESC_W;
	assign r_off  = r_word - DESC_W;
	assign w_desc = (w_word >= DESC_W) && (w_word < DESC_END);
	assign r_desc = (r_word >= DESC_W) && (r_word < DESC_END);
	assign w_idx  = w_off[`CNN_LAYER_IDX_W:1];                // two words per entry
	assign r_idx  = r_off[`CNN_LAYER_IDX_W:1];

	// write channel and register file
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bvalid      <= 1'b0;
			start_pulse <= 1'b0;
			num_layers  <= '0;
			for (int i = 0; i < `CNN_MAX_LAYERS; i++) begin
				desc_table[i] <= '0;
			end
		end else begin
			start_pulse <= w_fire && (w_word == CTRL_W) && axil_req.wdata[0]; // self clearing
			if (w_fire) begin
				bvalid <= 1'b1;
			end else if (axil_req.bready) begin
				bvalid <= 1'b0;                               // response taken
			end
			if (w_fire && (w_word == NUM_W)) begin
				num_layers <= axil_req.wdata[`CNN_LAYER_IDX_W:0];
			end
			if (w_fire && w_desc) begin
				if (!w_off[0]) begin                          // word 0
					desc_table[w_idx].kind        <= layer_kind_e'(axil_req.wdata[1:0]);
					desc_table[w_idx].activation  <= axil_req.wdata[2];
					desc_table[w_idx].pool_type   <= axil_req.wdata[3];
					desc_table[w_idx].kernel_size <= axil_req.wdata[8 +: `CNN_KERNEL_SIZE_W];
				end else begin                                // word 1
					desc_table[w_idx].fm_size_out <= axil_req.wdata[0 +: `CNN_FM_SIZE_W];
					desc_table[w_idx].kernel_num  <= axil_req.wdata[8 +: `CNN_KERNEL_NUM_W];
				end
			end
		end
	end

	// read mux, unmapped words fall through as zero
	always_comb begin
		rd_word = '0;
		if (r_word == STATUS_W) begin
			rd_word[1:0] = {done, busy};
		end else if (r_word == NUM_W) begin
			rd_word[`CNN_LAYER_IDX_W:0] = num_layers;
		end else if (r_word == CYCLES_W) begin
			rd_word[`CNN_CYCLE_W-1:0] = cycles;
		end else if (r_desc && !r_off[0]) begin
			rd_word[1:0]                        = desc_table[r_idx].kind;
			rd_word[2]                          = desc_table[r_idx].activation;
			rd_word[3]                          = desc_table[r_idx].pool_type;
			rd_word[8 +: `CNN_KERNEL_SIZE_W]    = desc_table[r_idx].kernel_size;
		end else if (r_desc) begin
			rd_word[0 +: `CNN_FM_SIZE_W]        = desc_table[r_idx].fm_size_out;
			rd_word[8 +: `CNN_KERNEL_NUM_W]     = desc_table[r_idx].kernel_num;
		end
	end

	// read channel state
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rvalid <= 1'b0;
		end else if (r_fire) begin
			rvalid <= 1'b1;
		end else if (axil_req.rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (r_fire) begin
			rdata <= rd_word;                                 // sampled at address phase
		end
	end

	always_comb begin
		axil_rsp.awready = w_fire;                            // aw and w ready pulse together
		axil_rsp.wready  = w_fire;
		axil_rsp.bvalid  = bvalid;
		axil_rsp.bresp   = 2'b00;                             // always okay
		axil_rsp.arready = r_fire;
		axil_rsp.rvalid  = rvalid;
		axil_rsp.rdata   = rdata;
		axil_rsp.rresp   = 2'b00;
	end

endmodule

/* hdl/layer_sequencer.sv */
`timescale 1ns/1ps
`include "cnn_defines.svh"

module layer_sequencer import cnn_pkg::*; (
	input  logic        clk,
	input  logic        rst,                                  // async, active low
	input  logic        start_pulse,
	input  num_layers_t num_layers,
	input  layer_desc_t desc_table [0:`CNN_MAX_LAYERS-1],
	input  logic        layer_done,                           // walker finished the layer
	output logic        layer_go,                             // high for the ISSUE cycle
	output layer_desc_t cur_desc,
	output logic        busy,
	output logic        done,
	output logic        stop,                                 // held until next start
	output cycle_cnt_t  cycles
);

	seq_state_e state;
	layer_idx_t layer_idx;
	layer_idx_t next_idx;
	layer_idx_t issue_idx;                                    // entry loaded on issue
	logic       start_ok;
	logic       last_layer;
	logic       issue_en;
	logic       in_run;                                       // counted states

	assign next_idx   = layer_idx + 1'b1;
	assign start_ok   = start_pulse && ((state == IDLE) || (state == DONE)); // busy ignores start
	// num_layers of 0 still runs entry 0
	assign last_layer = (layer_idx == layer_idx_t'(`CNN_MAX_LAYERS - 1)) ||
	                    (num_layers_t'(next_idx) >= num_layers);
	assign issue_en   = start_ok || ((state == NEXT) && !last_layer);
	assign issue_idx  = start_ok ? '0 : next_idx;
	assign in_run     = (state == ISSUE) || (state == RUN) || (state == NEXT);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= IDLE;
			layer_idx <= '0;
			layer_go  <= 1'b0;
			busy      <= 1'b0;
			done      <= 1'b0;
			stop      <= 1'b0;
			cycles    <= '0;
		end else begin
			layer_go <= issue_en;                             // lines up with ISSUE
			if (issue_en) begin
				layer_idx <= issue_idx;
			end
			if (in_run) begin
				cycles <= cycles + 1'b1;
			end
			case (state)
				IDLE, DONE: begin
					if (start_pulse) begin
						state  <= ISSUE;
						busy   <= 1'b1;
						done   <= 1'b0;
						stop   <= 1'b0;
						cycles <= '0;                         // fresh run
					end
				end
				ISSUE: begin
					state <= RUN;                             // walker starts next clock
				end
				RUN: begin
					if (layer_done) begin
						state <= NEXT;
					end
				end
				NEXT: begin
					if (last_layer) begin
						state <= DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
						stop  <= 1'b1;
					end else begin
						state <= ISSUE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// descriptor stays put for the whole layer
	always_ff @(posedge clk) begin
		if (issue_en) begin
			cur_desc <= desc_table[issue_idx];
		end
	end

endmodule

/* hdl/output_walker.sv */
`timescale 1ns/1ps
`include "cnn_defines.svh"

module output_walker import cnn_pkg::*; (
	input  logic        clk,
	input  logic        rst,                                  // async, active low
	input  logic        layer_go,                             // launch, one clock
	input  layer_desc_t cur_desc,
	output logic        pos_valid,
	output out_pos_t    pos,
	output logic        layer_done                            // with the last position
);

	localparam int unsigned GW = `CNN_KERNEL_NUM_W + 1;      // room for the rounding add

	localparam logic [GW-1:0] GRP_DIV = GW'(`CNN_PARA_KERNEL);
	localparam logic [GW-1:0] GRP_RND = GW'(`CNN_PARA_KERNEL - 1);

	logic          active;                                    // stream running
	fm_size_t      row;
	fm_size_t      col;
	kgroup_t       kgroup;
	fm_size_t      size_eff;                                  // zero size counts as one
	logic [GW-1:0] grp_cnt;                                   // ceil(kernel_num / PARA_KERNEL)
	kgroup_t       grp_last_nxt;
	fm_size_t      size_last;                                 // latched last row and col
	kgroup_t       grp_last;
	logic          col_end;
	logic          row_end;
	logic          grp_end;

	assign size_eff     = (cur_desc.fm_size_out == '0) ? fm_size_t'(1) : cur_desc.fm_size_out;
	assign grp_cnt      = ({1'b0, cur_desc.kernel_num} + GRP_RND) / GRP_DIV;
	assign grp_last_nxt = (grp_cnt == '0) ? '0 : kgroup_t'(grp_cnt - 1'b1); // no kernels, one group

	always_ff @(posedge clk) begin
		if (layer_go) begin
			size_last <= size_eff - 1'b1;
			grp_last  <= grp_last_nxt;
		end
	end

	assign col_end = (col == size_last);
	assign row_end = (row == size_last);
	assign grp_end = (kgroup == grp_last);

	// col innermost, then row, kgroup outermost
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			active <= 1'b0;
			row    <= '0;
			col    <= '0;
			kgroup <= '0;
		end else if (layer_go) begin
			active <= 1'b1;
			row    <= '0;
			col    <= '0;
			kgroup <= '0;
		end else if (active) begin
			if (!col_end) begin
				col <= col + 1'b1;
			end else begin
				col <= '0;
				if (!row_end) begin
					row <= row + 1'b1;
				end else begin
					row <= '0;
					if (grp_end) begin
						active <= 1'b0;                       // back to idle
					end else begin
						kgroup <= kgroup + 1'b1;
					end
				end
			end
		end
	end

	always_comb begin
		pos.row    = row;
		pos.col    = col;
		pos.kgroup = kgroup;
	end

	assign pos_valid  = active;                               // PE array takes every beat
	assign layer_done = active && col_end && row_end && grp_end;

endmodule

/* verilog.f */
+incdir+hdl
+incdir+dv
hdl/cnn_pkg.sv
hdl/layer_cfg_regs.sv
hdl/layer_sequencer.sv
hdl/output_walker.sv
hdl/cnn_ctrl_top.sv
dv/tb_clk_gen.sv
dv/tb_cnn_ctrl.sv
